//--- test/btb_cases.txt
// tag cmd a b c d e   (cmd 1 wb, 2 stall, 3 run)
// wb: a eip, b target, c pred_hit, d pred_target, e count (eip and target step 0x40)
// stall: a cycles, b exp eip, c exp pred_hit, d wb eip (0 none), e wb target
// run: a cycles, b exp eip, c exp pred_hit
1 3 8 00010070 0 0 0
2 1 00020100 00031234 0 0 1
2 3 3 00031250 0 0 0
3 1 00050000 00020100 0 0 1
3 3 1 00020100 1 0 0
3 3 1 00031234 0 0 0
4 1 00020100 00031234 1 00031234 1
4 3 1 00031260 0 0 0
4 1 00020100 00040008 1 00031234 1
4 3 1 00040008 0 0 0
4 1 00050000 00020100 0 0 1
4 3 1 00020100 1 0 0
4 3 1 00040008 0 0 0
5 1 00060000 00070000 0 0 3f
5 3 1 00070f80 0 0 0
5 1 00060000 00020100 0 0 1
5 3 1 00020100 0 0 0
5 1 00060040 00050000 0 0 1
5 3 1 00050000 1 0 0
5 3 1 00020100 0 0 0
6 2 4 00020110 0 0 0
6 2 4 00090040 0 00060080 00090040
6 3 2 00090060 0 0 0

//--- list.f
verilog/btb_pkg.sv
verilog/fetch_pkg.sv
verilog/btb_update_if.sv
verilog/branch_target_buff.sv
verilog/fetch_ip_unit.sv
verilog/wb_branch_unit.sv
verilog/fetch_frontend.sv
test/frontend_checker.sv
test/btb_properties.sv
test/fetch_frontend_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - verilog/btb_pkg.sv
  - verilog/fetch_pkg.sv
  - verilog/btb_update_if.sv
  - verilog/branch_target_buff.sv
  - verilog/fetch_ip_unit.sv
  - verilog/wb_branch_unit.sv
  - verilog/fetch_frontend.sv
  - target: test
    files:
      - test/frontend_checker.sv
      - test/btb_properties.sv
      - test/fetch_frontend_tb.sv

//--- test/fetch_frontend_tb.sv
`timescale 1ns/100ps

module fetch_frontend_tb;
    import btb_pkg::*;
    import fetch_pkg::*;

    localparam int MAX_RECORDS = 64;
    // tag, cmd and five fields per record
    localparam int REC_WORDS = 7;

    logic                      clk;
    logic                      reset;
    logic                      fetch_stall;
    logic                      wb_valid;
    logic [EIP_WIDTH-1:0]      wb_eip;
    logic [EIP_WIDTH-1:0]      wb_target;
    logic                      wb_pred_hit;
    logic [EIP_WIDTH-1:0]      wb_pred_target;
    logic [EIP_WIDTH-1:0]      fetch_eip;
    logic [LINE_PTR_WIDTH-1:0] fetch_fip_e;
    logic [LINE_PTR_WIDTH-1:0] fetch_fip_o;
    logic                      fetch_valid;
    fetch_src_e                fetch_src;
    logic                      pred_hit;
    logic [EIP_WIDTH-1:0]      pred_target;
    logic                      redirect;

    logic [31:0] cases [MAX_RECORDS*REC_WORDS];
    int          n_records = 0;
    int          max_run = 0;
    int          cycle_limit = 0;
    int          cycles = 0;

    fetch_frontend dut_i (
        .clk            (clk),
        .reset          (reset),
        .fetch_stall    (fetch_stall),
        .wb_valid       (wb_valid),
        .wb_eip         (wb_eip),
        .wb_target      (wb_target),
        .wb_pred_hit    (wb_pred_hit),
        .wb_pred_target (wb_pred_target),
        .fetch_eip      (fetch_eip),
        .fetch_fip_e    (fetch_fip_e),
        .fetch_fip_o    (fetch_fip_o),
        .fetch_valid    (fetch_valid),
        .pred_hit       (pred_hit),
        .pred_target    (pred_target),
        .redirect       (redirect)
    );

    // reason for the last eip change, no top-level port
    assign fetch_src = dut_i.fetch_ip_i.src;

    frontend_checker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0 && cycles >= cycle_limit);
        $display("simulation timed out after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    // back to back branches whose eip and target step by 0x40
    task automatic issue_branch(input logic [31:0] eip, input logic [31:0] target,
                                input logic phit, input logic [31:0] ptarget, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            wb_valid       <= 1'b1;
            wb_eip         <= eip + i * 32'h40;
            wb_target      <= target + i * 32'h40;
            wb_pred_hit    <= phit;
            wb_pred_target <= ptarget;
        end
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    // stall n cycles with an optional unpredicted branch at the start
    task automatic hold_fetch(input int n, input logic [31:0] exp_eip, input logic exp_hit,
                              input logic [31:0] br_eip, input logic [31:0] br_target);
        @(posedge clk);
        fetch_stall <= 1'b1;
        if (br_eip != 0) begin
            wb_valid       <= 1'b1;
            wb_eip         <= br_eip;
            wb_target      <= br_target;
            wb_pred_hit    <= 1'b0;
            wb_pred_target <= '0;
        end
        repeat (n) begin
            @(posedge clk);
            wb_valid <= 1'b0;
        end
        fetch_stall <= 1'b0;
        @(negedge clk);
        chk_i.expect_state(exp_eip, exp_hit);
    endtask

    task automatic run_cycles(input int n, input logic [31:0] exp_eip, input logic exp_hit);
        repeat (n) @(posedge clk);
        @(negedge clk);
        chk_i.expect_state(exp_eip, exp_hit);
    endtask

    initial begin : main
        int base;
        int prev_tag;
        reset          = 1'b1;
        fetch_stall    = 1'b0;
        wb_valid       = 1'b0;
        wb_eip         = '0;
        wb_target      = '0;
        wb_pred_hit    = 1'b0;
        wb_pred_target = '0;
        // cmd 0 marks the end of the records
        for (int i = 0; i < MAX_RECORDS * REC_WORDS; i++) begin
            cases[i] = '0;
        end
        $readmemh("test/btb_cases.txt", cases);
        while (n_records < MAX_RECORDS && cases[n_records*REC_WORDS+1] != 0) begin
            base = n_records * REC_WORDS;
            if (cases[base+1] == 3 && cases[base+2] > max_run) begin
                max_run = cases[base+2];
            end
            n_records++;
        end
        cycle_limit = n_records * 8 + max_run + 100;

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        prev_tag = cases[0];
        for (int r = 0; r < n_records; r++) begin
            base = r * REC_WORDS;
            if (cases[base] != prev_tag) begin
                chk_i.end_test(prev_tag);
                prev_tag = cases[base];
            end
            case (cases[base+1])
                1: issue_branch(cases[base+2], cases[base+3], cases[base+4][0],
                                cases[base+5], cases[base+6]);
                2: hold_fetch(cases[base+2], cases[base+3], cases[base+4][0],
                              cases[base+5], cases[base+6]);
                default: run_cycles(cases[base+2], cases[base+3], cases[base+4][0]);
            endcase
        end
        chk_i.end_test(prev_tag);

        $display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 chk_i.test_count, chk_i.check_count, chk_i.err_count,
                 dut_i.props_i.failures);
        if (chk_i.err_count == 0 && dut_i.props_i.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/btb_properties.sv
`timescale 1ns/100ps

module btb_properties (
    input logic                          clk,
    input logic                          reset,
    input logic                          fetch_stall,
    input logic                          redirect,
    input logic                          pred_hit,
    input logic [btb_pkg::EIP_WIDTH-1:0] fetch_eip,
    input logic [btb_pkg::EIP_WIDTH-1:0] redirect_target
);
    // failed assertion count, read by the testbench
    int failures = 0;

    // nothing predicted or redirected right out of reset
    reset_quiet: assert property (@(posedge clk) reset |=> (!redirect && !pred_hit))
        else begin
            $error("redirect or pred_hit high after a reset cycle");
            failures++;
        end

    // stall without redirect keeps the fetch eip
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        (fetch_stall && !redirect) |=> $stable(fetch_eip))
        else begin
            $error("fetch_eip moved while stalled");
            failures++;
        end

    // redirect lands one edge later
    redirect_load: assert property (@(posedge clk) disable iff (reset)
        redirect |=> (fetch_eip == $past(redirect_target)))
        else begin
            $error("fetch_eip is not the redirect target");
            failures++;
        end

endmodule

bind fetch_frontend btb_properties props_i (
    .clk             (clk),
    .reset           (reset),
    .fetch_stall     (fetch_stall),
    .redirect        (redirect),
    .pred_hit        (pred_hit),
    .fetch_eip       (fetch_eip),
    .redirect_target (redirect_target)
);

//--- test/frontend_checker.sv
`timescale 1ns/100ps

module frontend_checker (
    input logic                               clk,
    input logic                               reset,
    input logic                               fetch_stall,
    input logic                               wb_valid,
    input logic [btb_pkg::EIP_WIDTH-1:0]      wb_eip,
    input logic [btb_pkg::EIP_WIDTH-1:0]      wb_target,
    input logic                               wb_pred_hit,
    input logic [btb_pkg::EIP_WIDTH-1:0]      wb_pred_target,
    input logic [btb_pkg::EIP_WIDTH-1:0]      fetch_eip,
    input logic [btb_pkg::LINE_PTR_WIDTH-1:0] fetch_fip_e,
    input logic [btb_pkg::LINE_PTR_WIDTH-1:0] fetch_fip_o,
    input logic                               fetch_valid,
    input fetch_pkg::fetch_src_e              fetch_src,
    input logic                               pred_hit,
    input logic [btb_pkg::EIP_WIDTH-1:0]      pred_target,
    input logic                               redirect
);
    import btb_pkg::*;
    import fetch_pkg::*;

    // reference btb with each pair packed as {even, odd}
    logic                        m_valid [BTB_ENTRIES];
    logic [EIP_WIDTH-1:0]        m_tag [BTB_ENTRIES];
    logic [EIP_WIDTH-1:0]        m_target [BTB_ENTRIES];
    logic [2*LINE_PTR_WIDTH-1:0] m_pair [BTB_ENTRIES];
    int                          m_ring;
    // reference fetch state
    logic [EIP_WIDTH-1:0]        m_eip;
    logic [2*LINE_PTR_WIDTH-1:0] m_fpair;
    logic                        m_fvalid;
    fetch_src_e                  m_src;
    // writeback stage
    logic                        s_valid;
    logic                        s_phit;
    logic [EIP_WIDTH-1:0]        s_eip;
    logic [EIP_WIDTH-1:0]        s_target;
    logic [EIP_WIDTH-1:0]        s_ptarget;

    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_errs = 0;

    // line of addr and the one after with the even pointer first
    function automatic logic [2*LINE_PTR_WIDTH-1:0] expected_pair(input logic [EIP_WIDTH-1:0] addr);
        logic [LINE_PTR_WIDTH-1:0] line;
        line = addr / LINE_BYTES;
        if (line[0]) begin
            return {line + 28'd1, line};
        end
        return {line, line + 28'd1};
    endfunction

    // -1 on a miss
    function automatic int find_entry(input logic [EIP_WIDTH-1:0] addr);
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (m_valid[i] && m_tag[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin : model
        int  hit_idx;
        int  wr_idx;
        logic redir;
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
            end
            m_ring   = 0;
            m_eip    = RESET_EIP;
            m_fpair  = expected_pair(RESET_EIP);
            m_fvalid = 1'b0;
            m_src    = SRC_SEQ;
            s_valid  = 1'b0;
        end else begin
            // lookup sees the table before this edge's write
            hit_idx = find_entry(m_eip);
            redir   = s_valid && (!s_phit || s_ptarget != s_target);
            if (redir) begin
                m_eip   = s_target;
                m_fpair = expected_pair(s_target);
                m_src   = SRC_REDIRECT;
            end else if (!fetch_stall) begin
                if (hit_idx >= 0) begin
                    m_eip   = m_target[hit_idx];
                    m_fpair = m_pair[hit_idx];
                    m_src   = SRC_PRED;
                end else begin
                    m_eip   = (m_eip & ~32'hf) + LINE_BYTES;
                    m_fpair = expected_pair(m_eip);
                    m_src   = SRC_SEQ;
                end
            end
            // refresh in place, else allocate at the ring
            if (s_valid) begin
                wr_idx = find_entry(s_eip);
                if (wr_idx < 0) begin
                    wr_idx = m_ring;
                    m_ring = (m_ring + 1) % BTB_ENTRIES;
                end
                m_valid[wr_idx]  = 1'b1;
                m_tag[wr_idx]    = s_eip;
                m_target[wr_idx] = s_target;
                m_pair[wr_idx]   = expected_pair(s_target);
            end
            m_fvalid = 1'b1;
            s_valid  = wb_valid;
            if (wb_valid) begin
                s_eip     = wb_eip;
                s_target  = wb_target;
                s_phit    = wb_pred_hit;
                s_ptarget = wb_pred_target;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare
        int   idx;
        logic exp_redir;
        if (!reset) begin
            idx       = find_entry(m_eip);
            exp_redir = s_valid && (!s_phit || s_ptarget != s_target);
            check_field("fetch_eip", fetch_eip, m_eip);
            check_field("fetch_fip_e", fetch_fip_e, m_fpair[2*LINE_PTR_WIDTH-1:LINE_PTR_WIDTH]);
            check_field("fetch_fip_o", fetch_fip_o, m_fpair[LINE_PTR_WIDTH-1:0]);
            check_field("fetch_valid", fetch_valid, m_fvalid);
            check_field("fetch src", fetch_src, m_src);
            check_field("pred_hit", pred_hit, idx >= 0);
            check_field("redirect", redirect, exp_redir);
            if (idx >= 0) begin
                check_field("pred_target", pred_target, m_target[idx]);
            end
        end
    end

    // end state given by the cases file
    task automatic expect_state(input logic [31:0] exp_eip, input logic exp_hit);
        check_field("fetch_eip vs cases file", fetch_eip, exp_eip);
        check_field("pred_hit vs cases file", pred_hit, exp_hit);
    endtask

    task automatic end_test(input int tag);
        test_count++;
        if (err_count == test_errs) begin
            $display("test %0d done, no mismatches", tag);
        end else begin
            $display("test %0d done, %0d mismatches", tag, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

endmodule

//--- verilog/fetch_frontend.sv
`timescale 1ns/100ps

module fetch_frontend (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fetch_stall,
    input  logic                               wb_valid,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      wb_eip,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      wb_target,
    input  logic                               wb_pred_hit,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      wb_pred_target,
    output logic [btb_pkg::EIP_WIDTH-1:0]      fetch_eip,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fetch_fip_e,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fetch_fip_o,
    output logic                               fetch_valid,
    output logic                               pred_hit,
    output logic [btb_pkg::EIP_WIDTH-1:0]      pred_target,
    output logic                               redirect
);
    import btb_pkg::*;

    // stored line pair of the predicted target
    logic [LINE_PTR_WIDTH-1:0] pred_fip_e;
    logic [LINE_PTR_WIDTH-1:0] pred_fip_o;
    logic [EIP_WIDTH-1:0]      redirect_target;

    // writeback to btb update path
    btb_update_if upd_if ();

    // lookup on the current fetch eip
    branch_target_buff btb_i (
        .clk          (clk),
        .reset        (reset),
        .lookup_eip   (fetch_eip),
        .upd          (upd_if.btb),
        .hit          (pred_hit),
        .target       (pred_target),
        .fip_e_target (pred_fip_e),
        .fip_o_target (pred_fip_o)
    );

    // src is left for debug probing
    fetch_ip_unit fetch_ip_i (
        .clk             (clk),
        .reset           (reset),
        .stall           (fetch_stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pred_hit        (pred_hit),
        .pred_target     (pred_target),
        .pred_fip_e      (pred_fip_e),
        .pred_fip_o      (pred_fip_o),
        .eip             (fetch_eip),
        .fip_e           (fetch_fip_e),
        .fip_o           (fetch_fip_o),
        .fetch_valid     (fetch_valid),
        .src             ()
    );

    wb_branch_unit wb_branch_i (
        .clk             (clk),
        .reset           (reset),
        .wb_valid        (wb_valid),
        .wb_eip          (wb_eip),
        .wb_target       (wb_target),
        .wb_pred_hit     (wb_pred_hit),
        .wb_pred_target  (wb_pred_target),
        .upd             (upd_if.wb),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

endmodule

//--- verilog/wb_branch_unit.sv
`timescale 1ns/100ps

module wb_branch_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wb_valid,
    input  logic [btb_pkg::EIP_WIDTH-1:0] wb_eip,
    input  logic [btb_pkg::EIP_WIDTH-1:0] wb_target,
    input  logic                          wb_pred_hit,
    input  logic [btb_pkg::EIP_WIDTH-1:0] wb_pred_target,
    btb_update_if.wb                      upd,
    output logic                          redirect,
    output logic [btb_pkg::EIP_WIDTH-1:0] redirect_target
);
    import btb_pkg::*;
    import fetch_pkg::*;

    // writeback latch
    logic                 valid_q;
    logic [EIP_WIDTH-1:0] eip_q;
    logic [EIP_WIDTH-1:0] target_q;
    logic                 pred_hit_q;
    logic [EIP_WIDTH-1:0] pred_target_q;
    line_pair_t           target_pair;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wb_valid;
        end
    end

    // branch payload
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            eip_q         <= wb_eip;
            target_q      <= wb_target;
            pred_hit_q    <= wb_pred_hit;
            pred_target_q <= wb_pred_target;
        end
    end

    assign target_pair = line_pair(target_q);

    // every resolved branch refreshes the btb
    assign upd.ld         = valid_q;
    assign upd.branch_eip = eip_q;
    assign upd.target     = target_q;
    assign upd.fip_e      = target_pair.fip_e;
    assign upd.fip_o      = target_pair.fip_o;

    // not predicted, or predicted to the wrong place
    assign redirect        = valid_q && (!pred_hit_q || (pred_target_q != target_q));
    assign redirect_target = target_q;

endmodule

//--- verilog/fetch_ip_unit.sv
`timescale 1ns/100ps

module fetch_ip_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall,
    input  logic                               redirect,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      redirect_target,
    input  logic                               pred_hit,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      pred_target,
    input  logic [btb_pkg::LINE_PTR_WIDTH-1:0] pred_fip_e,
    input  logic [btb_pkg::LINE_PTR_WIDTH-1:0] pred_fip_o,
    output logic [btb_pkg::EIP_WIDTH-1:0]      eip,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fip_e,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fip_o,
    output logic                               fetch_valid,
    output fetch_pkg::fetch_src_e              src
);
    import btb_pkg::*;
    import fetch_pkg::*;

    logic [EIP_WIDTH-1:0] seq_eip;
    line_pair_t           seq_pair;
    line_pair_t           redir_pair;
    line_pair_t           reset_pair;

    // start of the next line
    assign seq_eip    = {eip[EIP_WIDTH-1:LINE_OFFSET] + 1'b1, {LINE_OFFSET{1'b0}}};
    assign seq_pair   = line_pair(seq_eip);
    assign redir_pair = line_pair(redirect_target);
    assign reset_pair = line_pair(RESET_EIP);

    always_ff @(posedge clk) begin
        if (reset) begin
            eip         <= RESET_EIP;
            fip_e       <= reset_pair.fip_e;
            fip_o       <= reset_pair.fip_o;
            fetch_valid <= 1'b0;
            src         <= SRC_SEQ;
        end else begin
            fetch_valid <= 1'b1;
            // redirect wins, even over a stall
            if (redirect) begin
                eip   <= redirect_target;
                fip_e <= redir_pair.fip_e;
                fip_o <= redir_pair.fip_o;
                src   <= SRC_REDIRECT;
            end else if (!stall) begin
                if (pred_hit) begin
                    // stored pointers, no recompute
                    eip   <= pred_target;
                    fip_e <= pred_fip_e;
                    fip_o <= pred_fip_o;
                    src   <= SRC_PRED;
                end else begin
                    eip   <= seq_eip;
                    fip_e <= seq_pair.fip_e;
                    fip_o <= seq_pair.fip_o;
                    src   <= SRC_SEQ;
                end
            end
        end
    end

endmodule

//--- verilog/branch_target_buff.sv
`timescale 1ns/100ps

module branch_target_buff (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [btb_pkg::EIP_WIDTH-1:0]      lookup_eip,
    btb_update_if.btb                          upd,
    output logic                               hit,
    output logic [btb_pkg::EIP_WIDTH-1:0]      target,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fip_e_target,
    output logic [btb_pkg::LINE_PTR_WIDTH-1:0] fip_o_target
);
    import btb_pkg::*;

    // entry storage
    btb_entry_t entries [BTB_ENTRIES];

    // one-hot match vectors
    logic [BTB_ENTRIES-1:0] rd_match;
    logic [BTB_ENTRIES-1:0] wr_match;
    // victim pointer
    logic [BTB_ENTRIES-1:0] ring;
    // slot written by this update
    logic [BTB_ENTRIES-1:0] wr_sel;
    logic                   upd_hit;

    btb_entry_t sel_entry;
    btb_entry_t new_entry;

    // tag compare for fetch and for update
    always_comb begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            rd_match[i] = entries[i].valid && (entries[i].tag == lookup_eip);
            wr_match[i] = entries[i].valid && (entries[i].tag == upd.branch_eip);
        end
    end

    // and-or mux, rd_match is one-hot
    always_comb begin
        sel_entry = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            sel_entry = sel_entry | (entries[i] & {$bits(btb_entry_t){rd_match[i]}});
        end
    end

    // valid bit of the selected entry doubles as hit
    assign hit          = sel_entry.valid;
    assign target       = sel_entry.target;
    assign fip_e_target = sel_entry.fip_e;
    assign fip_o_target = sel_entry.fip_o;

    // existing branch is refreshed in place
    assign upd_hit = |wr_match;
    // else the ring picks the victim
    assign wr_sel  = upd_hit ? wr_match : ring;

    always_comb begin
        new_entry.valid  = 1'b1;
        new_entry.tag    = upd.branch_eip;
        new_entry.target = upd.target;
        new_entry.fip_e  = upd.fip_e;
        new_entry.fip_o  = upd.fip_o;
    end

    // entry write
    always_ff @(posedge clk) begin
        if (reset) begin
            // only the valid bits are cleared
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd.ld) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                if (wr_sel[i]) begin
                    entries[i] <= new_entry;
                end
            end
        end
    end

    // victim ring, starts at entry 0
    always_ff @(posedge clk) begin
        if (reset) begin
            ring <= {{(BTB_ENTRIES-1){1'b0}}, 1'b1};
        end else if (upd.ld && !upd_hit) begin
            // rotate left once per allocation
            ring <= {ring[BTB_ENTRIES-2:0], ring[BTB_ENTRIES-1]};
        end
    end

endmodule

//--- verilog/btb_update_if.sv
`timescale 1ns/100ps

interface btb_update_if;
    import btb_pkg::*;

    // one-cycle write strobe
    logic                      ld;
    // resolved branch, used as the tag
    logic [EIP_WIDTH-1:0]      branch_eip;
    logic [EIP_WIDTH-1:0]      target;
    // line pair of the target
    logic [LINE_PTR_WIDTH-1:0] fip_e;
    logic [LINE_PTR_WIDTH-1:0] fip_o;

    // writeback side
    modport wb (
        output ld,
        output branch_eip,
        output target,
        output fip_e,
        output fip_o
    );

    // btb side
    modport btb (
        input ld,
        input branch_eip,
        input target,
        input fip_e,
        input fip_o
    );

endinterface

//--- verilog/fetch_pkg.sv
package fetch_pkg;
    import btb_pkg::*;

    // fetch address out of reset
    localparam logic [EIP_WIDTH-1:0] RESET_EIP = 32'h0000_fff0;
    localparam int unsigned LINE_BYTES = 16;
    // byte offset bits inside a line
    localparam int unsigned LINE_OFFSET = $clog2(LINE_BYTES);

    // why the fetch eip last changed
    typedef enum logic [1:0] {
        SRC_SEQ,
        SRC_PRED,
        SRC_REDIRECT
    } fetch_src_e;

    typedef struct packed {
        logic [LINE_PTR_WIDTH-1:0] fip_e;
        logic [LINE_PTR_WIDTH-1:0] fip_o;
    } line_pair_t;

    // line holding addr plus the next line, sorted into even and odd
    function automatic line_pair_t line_pair(input logic [EIP_WIDTH-1:0] addr);
        logic [LINE_PTR_WIDTH-1:0] line;
        logic [LINE_PTR_WIDTH-1:0] next_line;
        line_pair_t                pair;
        line      = addr[EIP_WIDTH-1:LINE_OFFSET];
        next_line = line + 1'b1;
        if (line[0]) begin
            // odd line, the neighbour is the even one
            pair.fip_e = next_line;
            pair.fip_o = line;
        end else begin
            pair.fip_e = line;
            pair.fip_o = next_line;
        end
        return pair;
    endfunction

endpackage

//--- verilog/btb_pkg.sv
package btb_pkg;

    // fully associative, one-hot ring replacement
    localparam int unsigned BTB_ENTRIES = 64;

    // eip and branch target width
    localparam int unsigned EIP_WIDTH = 32;

    // fetch-line pointer, eip without the byte offset
    localparam int unsigned LINE_PTR_WIDTH = 28;

    // one btb entry, 121 bits
    typedef struct packed {
        logic                      valid;
        // full branch eip, no index bits
        logic [EIP_WIDTH-1:0]      tag;
        logic [EIP_WIDTH-1:0]      target;
        // even and odd line pointers of the target
        logic [LINE_PTR_WIDTH-1:0] fip_e;
        logic [LINE_PTR_WIDTH-1:0] fip_o;
    } btb_entry_t;

endpackage
